// ==== sdram_macros.svh ====
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// Power-up wait of 200 us at 50 MHz
`define SDRAM_INIT_CYCLES 10000

// 64 ms / 8192 rows at 20 ns per cycle
`define SDRAM_REFRESH_INTERVAL 390

`define SDRAM_CAS_LATENCY 3
`define SDRAM_INIT_REFRESHES 8

// Burst length 1 with sequential order and CL3
`define SDRAM_MODE_WORD 12'h030

// Word address geometry
`define SDRAM_ROW_BITS 12
`define SDRAM_COL_BITS 8
`define SDRAM_BANK_BITS 2

`endif

// ==== busPkg.sv ====
package busPkg;

	// {bank[21:20], row[19:8], col[7:0]}
	typedef logic [21:0] addrT;

	typedef logic [15:0] dataT;

	// One bit per byte lane with bit 1 on dq[15:8]
	typedef logic [1:0] strbT;

	// Host port index
	typedef logic portIdT;

endpackage

// ==== sdramPkg.sv ====
package sdramPkg;

	// {csN, rasN, casN, weN}
	typedef enum logic [3:0] {
		MRS           = 4'b0000,
		REFRESH       = 4'b0001,
		PRECHARGE_ALL = 4'b0010,
		ACT           = 4'b0011,
		WRITEA        = 4'b0100,
		READA         = 4'b0101,
		NOP           = 4'b1111 // Chip deselected
	} sdramCmdT;

	typedef enum logic [4:0] {
		ST_INIT_WAIT,
		ST_INIT_PALL,
		ST_INIT_DLY,
		ST_INIT_REF,
		ST_INIT_TRC1,
		ST_INIT_TRC2,
		ST_INIT_MRS,
		ST_IDLE,
		ST_ACT,
		ST_TRCD,
		ST_WRITEA,
		ST_WR_REC1,
		ST_WR_REC2,
		ST_READA,
		ST_RD_CL1,
		ST_RD_CL2,
		ST_RD_CAPTURE,
		ST_REF,
		ST_REF_TRC1,
		ST_REF_TRC2,
		ST_REF_TRC3,
		ST_DONE
	} ctrlStateT;

endpackage

// ==== apbPort.sv ====
`timescale 1ns/10ps

module apbPort (
	input  logic          sys_clk,
	input  logic          rstn,
	input  logic          pSel,
	input  logic          pEnable,
	input  logic          pWrite,
	input  busPkg::addrT  pAddr,
	input  busPkg::dataT  pWdata,
	input  busPkg::strbT  pStrb,
	input  logic          reqDone,
	input  busPkg::dataT  reqRdata,
	output busPkg::dataT  pRdata,
	output logic          pReady,
	output logic          reqValid,
	output logic          reqWrite,
	output busPkg::addrT  reqAddr,
	output busPkg::dataT  reqWdata,
	output busPkg::strbT  reqStrb
);

	logic startXfer;

	// Access phase of a new transfer but not its completing cycle
	assign startXfer = pSel && pEnable && !reqValid && !pReady;

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			reqValid <= 1'b0;
			reqWrite <= 1'b0;
			reqAddr  <= '0;
			reqWdata <= '0;
			reqStrb  <= '0;
			pReady   <= 1'b0;
			pRdata   <= '0;
		end else begin
			pReady <= 1'b0; // Single-cycle completion
			if (startXfer) begin
				reqValid <= 1'b1;
				reqWrite <= pWrite;
				reqAddr  <= pAddr;
				reqWdata <= pWdata;
				reqStrb  <= pStrb;
			end else if (reqDone) begin
				reqValid <= 1'b0;
				pReady   <= 1'b1;
				pRdata   <= reqRdata; // Don't care for writes
			end
		end
	end

	// Held request mirrors the APB transfer still in progress
	reqHeld: assert property (@(posedge sys_clk) disable iff (!rstn)
		reqValid && pSel && pEnable |->
		{reqWrite, reqAddr, reqWdata, reqStrb} == {pWrite, pAddr, pWdata, pStrb});

endmodule

// ==== portArbiter.sv ====
`timescale 1ns/10ps

module portArbiter (
	input  logic          sys_clk,
	input  logic          rstn,
	input  logic          rqValid0,
	input  logic          rqWrite0,
	input  busPkg::addrT  rqAddr0,
	input  busPkg::dataT  rqWdata0,
	input  busPkg::strbT  rqStrb0,
	input  logic          rqValid1,
	input  logic          rqWrite1,
	input  busPkg::addrT  rqAddr1,
	input  busPkg::dataT  rqWdata1,
	input  busPkg::strbT  rqStrb1,
	input  logic          cmdAccept,
	input  logic          cmdDone,
	input  busPkg::dataT  cmdRdata,
	output logic          rqDone0,
	output busPkg::dataT  rqRdata0,
	output logic          rqDone1,
	output busPkg::dataT  rqRdata1,
	output logic          cmdValid,
	output logic          cmdWrite,
	output busPkg::addrT  cmdAddr,
	output busPkg::dataT  cmdWdata,
	output busPkg::strbT  cmdStrb
);

	busPkg::portIdT lastServed;
	busPkg::portIdT pick;
	busPkg::portIdT grant;
	logic           busy;

	// Other port first when it is asking
	assign pick  = (lastServed ? rqValid0 : rqValid1) ? ~lastServed : lastServed;
	assign grant = busy ? lastServed : pick;

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			lastServed <= 1'b1; // Port 0 wins the first round
			busy       <= 1'b0;
		end else if (cmdAccept) begin
			lastServed <= grant;
			busy       <= 1'b1;
		end else if (cmdDone) begin
			busy <= 1'b0;
		end
	end

	assign cmdValid = grant ? rqValid1 : rqValid0;
	assign cmdWrite = grant ? rqWrite1 : rqWrite0;
	assign cmdAddr  = grant ? rqAddr1  : rqAddr0;
	assign cmdWdata = grant ? rqWdata1 : rqWdata0;
	assign cmdStrb  = grant ? rqStrb1  : rqStrb0;

	// Done goes to the owner only while read data is shared
	assign rqDone0  = cmdDone && busy && !lastServed;
	assign rqDone1  = cmdDone && busy && lastServed;
	assign rqRdata0 = cmdRdata;
	assign rqRdata1 = cmdRdata;

	grantLocked: assert property (@(posedge sys_clk) disable iff (!rstn)
		busy && !cmdDone |=> grant == $past(grant));

	// A done pulse needs an owner that is still asking
	doneOwned: assert property (@(posedge sys_clk) disable iff (!rstn)
		cmdDone |-> busy && (lastServed ? rqValid1 : rqValid0));

endmodule

// ==== sdramController.sv ====
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdramController (
	input  logic                        sys_clk,
	input  logic                        rstn,
	input  logic                        cmdValid,
	input  logic                        cmdWrite,
	input  busPkg::addrT                cmdAddr,
	input  busPkg::dataT                cmdWdata,
	input  busPkg::strbT                cmdStrb,
	output logic                        cmdAccept,
	output logic                        cmdDone,
	output busPkg::dataT                cmdRdata,
	output logic                        csN,
	output logic                        rasN,
	output logic                        casN,
	output logic                        weN,
	output logic [`SDRAM_BANK_BITS-1:0] ba,
	output logic [`SDRAM_ROW_BITS-1:0]  addr,
	inout  wire  [15:0]                 dq,
	output busPkg::strbT                dqm
);

	localparam int INIT_CNT_W = $clog2(`SDRAM_INIT_CYCLES);
	localparam int INIT_REF_W = $clog2(`SDRAM_INIT_REFRESHES);
	localparam int REF_CNT_W  = $clog2(`SDRAM_REFRESH_INTERVAL + 8);
	localparam int BANK_LSB   = `SDRAM_COL_BITS + `SDRAM_ROW_BITS;

	sdramPkg::ctrlStateT state;
	sdramPkg::ctrlStateT next;
	sdramPkg::sdramCmdT  cmdPins;

	logic [INIT_CNT_W-1:0] initCnt;
	logic [INIT_REF_W-1:0] initRefCnt;
	logic [REF_CNT_W-1:0]  refCnt;
	logic                  initDone;
	logic                  initCntDone;
	logic                  lastInitRef;
	logic                  refreshDue;
	logic                  dqOe;

	// Command held for the whole access
	logic         latWrite;
	busPkg::addrT latAddr;
	busPkg::dataT latWdata;
	busPkg::strbT latStrb;

	assign initCntDone = initCnt == INIT_CNT_W'(`SDRAM_INIT_CYCLES - 1);
	assign lastInitRef = initRefCnt == INIT_REF_W'(`SDRAM_INIT_REFRESHES - 1);
	// refCnt counts cycles since REFRESH
	// The command itself lands one cycle after idle
	assign refreshDue  = initDone && (refCnt >= REF_CNT_W'(`SDRAM_REFRESH_INTERVAL - 1));

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state      <= sdramPkg::ST_INIT_WAIT;
			initCnt    <= '0;
			initRefCnt <= '0;
			refCnt     <= '0;
			initDone   <= 1'b0;
		end else begin
			state <= next;
			if (state == sdramPkg::ST_INIT_WAIT && !initCntDone)
				initCnt <= initCnt + INIT_CNT_W'(1);
			if (state == sdramPkg::ST_INIT_TRC2)
				initRefCnt <= initRefCnt + INIT_REF_W'(1);
			if (state == sdramPkg::ST_INIT_REF || state == sdramPkg::ST_REF)
				refCnt <= REF_CNT_W'(1);
			else
				refCnt <= refCnt + REF_CNT_W'(1); // Wraps harmlessly during power-up wait
			if (state == sdramPkg::ST_INIT_MRS)
				initDone <= 1'b1;
		end
	end

	always_comb begin
		next = state;
		case (state)
			sdramPkg::ST_INIT_WAIT:  if (initCntDone) next = sdramPkg::ST_INIT_PALL;
			sdramPkg::ST_INIT_PALL:  next = sdramPkg::ST_INIT_DLY;
			sdramPkg::ST_INIT_DLY:   next = sdramPkg::ST_INIT_REF;
			sdramPkg::ST_INIT_REF:   next = sdramPkg::ST_INIT_TRC1;
			sdramPkg::ST_INIT_TRC1:  next = sdramPkg::ST_INIT_TRC2;
			sdramPkg::ST_INIT_TRC2:
				next = lastInitRef ? sdramPkg::ST_INIT_MRS : sdramPkg::ST_INIT_DLY;
			sdramPkg::ST_INIT_MRS:   next = sdramPkg::ST_IDLE;
			sdramPkg::ST_IDLE: begin
				if (refreshDue)
					next = sdramPkg::ST_REF; // Refresh beats host traffic
				else if (cmdValid)
					next = sdramPkg::ST_ACT;
			end
			sdramPkg::ST_ACT:        next = sdramPkg::ST_TRCD;
			sdramPkg::ST_TRCD:
				next = latWrite ? sdramPkg::ST_WRITEA : sdramPkg::ST_READA;
			sdramPkg::ST_WRITEA:     next = sdramPkg::ST_WR_REC1;
			sdramPkg::ST_WR_REC1:    next = sdramPkg::ST_WR_REC2;
			sdramPkg::ST_WR_REC2:    next = sdramPkg::ST_DONE;
			sdramPkg::ST_READA:      next = sdramPkg::ST_RD_CL1;
			sdramPkg::ST_RD_CL1:     next = sdramPkg::ST_RD_CL2;
			sdramPkg::ST_RD_CL2:     next = sdramPkg::ST_RD_CAPTURE;
			sdramPkg::ST_RD_CAPTURE: next = sdramPkg::ST_DONE;
			sdramPkg::ST_REF:        next = sdramPkg::ST_REF_TRC1;
			sdramPkg::ST_REF_TRC1:   next = sdramPkg::ST_REF_TRC2;
			sdramPkg::ST_REF_TRC2:   next = sdramPkg::ST_REF_TRC3;
			sdramPkg::ST_REF_TRC3:   next = sdramPkg::ST_IDLE;
			sdramPkg::ST_DONE:       next = sdramPkg::ST_IDLE;
			default:                 next = sdramPkg::ST_IDLE;
		endcase
	end

	assign cmdAccept = (state == sdramPkg::ST_IDLE) && !refreshDue && cmdValid;
	assign cmdDone   = state == sdramPkg::ST_DONE;

	always_ff @(posedge sys_clk) begin
		if (cmdAccept) begin
			latWrite <= cmdWrite;
			latAddr  <= cmdAddr;
			latWdata <= cmdWdata;
			latStrb  <= cmdStrb;
		end
	end

	// Sample dq CAS latency cycles after READA
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			cmdRdata <= '0;
		else if (state == sdramPkg::ST_RD_CAPTURE)
			cmdRdata <= dq;
	end

	always_comb begin
		case (state)
			sdramPkg::ST_INIT_PALL:                  cmdPins = sdramPkg::PRECHARGE_ALL;
			sdramPkg::ST_INIT_REF, sdramPkg::ST_REF: cmdPins = sdramPkg::REFRESH;
			sdramPkg::ST_INIT_MRS:                   cmdPins = sdramPkg::MRS;
			sdramPkg::ST_ACT:                        cmdPins = sdramPkg::ACT;
			sdramPkg::ST_WRITEA:                     cmdPins = sdramPkg::WRITEA;
			sdramPkg::ST_READA:                      cmdPins = sdramPkg::READA;
			default:                                 cmdPins = sdramPkg::NOP;
		endcase
	end

	assign {csN, rasN, casN, weN} = cmdPins;

	always_comb begin
		addr = '0;
		ba   = '0;
		case (state)
			sdramPkg::ST_INIT_PALL: addr[10] = 1'b1; // All banks
			sdramPkg::ST_INIT_MRS:  addr = `SDRAM_MODE_WORD;
			sdramPkg::ST_ACT: begin
				ba   = latAddr[BANK_LSB +: `SDRAM_BANK_BITS];
				addr = latAddr[`SDRAM_COL_BITS +: `SDRAM_ROW_BITS];
			end
			sdramPkg::ST_WRITEA, sdramPkg::ST_READA: begin
				ba                         = latAddr[BANK_LSB +: `SDRAM_BANK_BITS];
				addr[`SDRAM_COL_BITS-1:0] = latAddr[`SDRAM_COL_BITS-1:0];
				addr[10]                   = 1'b1; // Auto-precharge
			end
			default: ;
		endcase
	end

	assign dqOe = state == sdramPkg::ST_WRITEA;
	assign dq   = dqOe ? latWdata : 16'hzzzz;
	assign dqm  = dqOe ? ~latStrb : 2'b00; // Reads always return both bytes

	noEarlyAccept: assert property (@(posedge sys_clk) disable iff (!rstn)
		cmdAccept |-> initDone);

	// No other driver on dq while the write word is out
	dqNoContention: assert property (@(posedge sys_clk) disable iff (!rstn)
		dqOe |-> dq == latWdata);

	// Worst case a read is in flight when refresh falls due
	refreshBound: assert property (@(posedge sys_clk) disable iff (!rstn)
		$rose(refreshDue) |-> ##[1:8] (cmdPins == sdramPkg::REFRESH));

endmodule

// ==== sdramSubsystem.sv ====
`timescale 1ns/10ps

module sdramSubsystem (
	input  logic          sys_clk,
	input  logic          rstn,
	input  logic          p0Sel,
	input  logic          p0Enable,
	input  logic          p0Write,
	input  busPkg::addrT  p0Addr,
	input  busPkg::dataT  p0Wdata,
	input  busPkg::strbT  p0Strb,
	output busPkg::dataT  p0Rdata,
	output logic          p0Ready,
	input  logic          p1Sel,
	input  logic          p1Enable,
	input  logic          p1Write,
	input  busPkg::addrT  p1Addr,
	input  busPkg::dataT  p1Wdata,
	input  busPkg::strbT  p1Strb,
	output busPkg::dataT  p1Rdata,
	output logic          p1Ready,
	output logic          csN,
	output logic          rasN,
	output logic          casN,
	output logic          weN,
	output logic [1:0]    ba,
	output logic [11:0]   addr,
	inout  wire  [15:0]   dq,
	output busPkg::strbT  dqm
);

	// Port side requests
	logic         rqValid0, rqWrite0, rqDone0;
	logic         rqValid1, rqWrite1, rqDone1;
	busPkg::addrT rqAddr0, rqAddr1;
	busPkg::dataT rqWdata0, rqWdata1, rqRdata0, rqRdata1;
	busPkg::strbT rqStrb0, rqStrb1;

	// Granted command to the controller
	logic         cmdValid, cmdWrite, cmdAccept, cmdDone;
	busPkg::addrT cmdAddr;
	busPkg::dataT cmdWdata, cmdRdata;
	busPkg::strbT cmdStrb;

	apbPort port0 (
		.sys_clk(sys_clk), .rstn(rstn),
		.pSel(p0Sel), .pEnable(p0Enable), .pWrite(p0Write),
		.pAddr(p0Addr), .pWdata(p0Wdata), .pStrb(p0Strb),
		.reqDone(rqDone0), .reqRdata(rqRdata0),
		.pRdata(p0Rdata), .pReady(p0Ready),
		.reqValid(rqValid0), .reqWrite(rqWrite0), .reqAddr(rqAddr0),
		.reqWdata(rqWdata0), .reqStrb(rqStrb0)
	);

	apbPort port1 (
		.sys_clk(sys_clk), .rstn(rstn),
		.pSel(p1Sel), .pEnable(p1Enable), .pWrite(p1Write),
		.pAddr(p1Addr), .pWdata(p1Wdata), .pStrb(p1Strb),
		.reqDone(rqDone1), .reqRdata(rqRdata1),
		.pRdata(p1Rdata), .pReady(p1Ready),
		.reqValid(rqValid1), .reqWrite(rqWrite1), .reqAddr(rqAddr1),
		.reqWdata(rqWdata1), .reqStrb(rqStrb1)
	);

	portArbiter arb0 (
		.sys_clk(sys_clk), .rstn(rstn),
		.rqValid0(rqValid0), .rqWrite0(rqWrite0), .rqAddr0(rqAddr0),
		.rqWdata0(rqWdata0), .rqStrb0(rqStrb0),
		.rqValid1(rqValid1), .rqWrite1(rqWrite1), .rqAddr1(rqAddr1),
		.rqWdata1(rqWdata1), .rqStrb1(rqStrb1),
		.cmdAccept(cmdAccept), .cmdDone(cmdDone), .cmdRdata(cmdRdata),
		.rqDone0(rqDone0), .rqRdata0(rqRdata0),
		.rqDone1(rqDone1), .rqRdata1(rqRdata1),
		.cmdValid(cmdValid), .cmdWrite(cmdWrite), .cmdAddr(cmdAddr),
		.cmdWdata(cmdWdata), .cmdStrb(cmdStrb)
	);

	sdramController ctrl0 (
		.sys_clk(sys_clk), .rstn(rstn),
		.cmdValid(cmdValid), .cmdWrite(cmdWrite), .cmdAddr(cmdAddr),
		.cmdWdata(cmdWdata), .cmdStrb(cmdStrb),
		.cmdAccept(cmdAccept), .cmdDone(cmdDone), .cmdRdata(cmdRdata),
		.csN(csN), .rasN(rasN), .casN(casN), .weN(weN),
		.ba(ba), .addr(addr), .dq(dq), .dqm(dqm)
	);

endmodule

// ==== tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
	output logic sys_clk,
	output logic rstn
);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk; // 20 ns period
	end

	initial begin
		rstn = 1'b0;
		repeat (10) @(posedge sys_clk);
		#2;
		rstn = 1'b1;
	end

endmodule

// ==== sdramModel.sv ====
`timescale 1ns/10ps
`include "sdram_macros.svh"

module sdramModel (
	input  logic        sys_clk,
	input  logic        rstn,
	input  logic        csN,
	input  logic        rasN,
	input  logic        casN,
	input  logic        weN,
	input  logic [1:0]  ba,
	input  logic [11:0] addr,
	inout  wire  [15:0] dq,
	input  logic [1:0]  dqm
);

	localparam int CL = `SDRAM_CAS_LATENCY;

	sdramPkg::sdramCmdT cmd;
	logic [15:0] mem [logic [21:0]];
	logic [11:0] openRow [4];
	logic [21:0] wordAddr;
	logic [15:0] word;
	logic [15:0] rdData;
	logic        rdEn;
	int          rdCnt;

	// Observed by the testbench
	int          cycle;
	int          lastRef;
	int          maxRefGap;
	int          refreshes;
	int          initRefs;
	logic        mrsSeen;
	logic        actSeen;
	logic        mrsBeforeAct;
	logic [11:0] mrsWord;

	assign cmd      = sdramPkg::sdramCmdT'({csN, rasN, casN, weN});
	assign wordAddr = {ba, openRow[ba], addr[7:0]}; // Same layout as the host address
	assign dq       = rdEn ? rdData : 16'hzzzz;

	always @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			cycle        <= 0;
			lastRef      <= 0;
			maxRefGap    <= 0;
			refreshes    <= 0;
			initRefs     <= 0;
			mrsSeen      <= 1'b0;
			actSeen      <= 1'b0;
			mrsBeforeAct <= 1'b0;
			mrsWord      <= '0;
			rdEn         <= 1'b0;
			rdCnt        <= 0;
		end else begin
			cycle <= cycle + 1;
			if (rdCnt != 0)
				rdCnt <= rdCnt - 1;
			rdEn <= rdCnt == CL - 1; // Data valid on the sampling edge
			case (cmd)
				sdramPkg::ACT: begin
					openRow[ba] <= addr;
					if (!actSeen) begin
						actSeen      <= 1'b1;
						mrsBeforeAct <= mrsSeen;
					end
				end
				sdramPkg::WRITEA: begin
					word = mem.exists(wordAddr) ? mem[wordAddr] : 16'hxxxx;
					if (!dqm[0])
						word[7:0] = dq[7:0];
					if (!dqm[1])
						word[15:8] = dq[15:8];
					mem[wordAddr] = word;
				end
				sdramPkg::READA: begin
					rdData <= mem.exists(wordAddr) ? mem[wordAddr] : 16'hxxxx;
					rdCnt  <= CL;
				end
				sdramPkg::REFRESH: begin
					refreshes <= refreshes + 1;
					lastRef   <= cycle;
					if (refreshes > 0 && cycle - lastRef > maxRefGap)
						maxRefGap <= cycle - lastRef;
					if (!mrsSeen)
						initRefs <= initRefs + 1;
				end
				sdramPkg::MRS: begin
					mrsSeen <= 1'b1;
					mrsWord <= addr;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== tb_sdram.sv ====
`timescale 1ns/10ps
`include "sdram_macros.svh"

module tb_sdram;

	localparam int WAIT_LIMIT = 20000; // Covers the power-up wait
	localparam int REF_BOUND  = `SDRAM_REFRESH_INTERVAL + 7;

	logic         sys_clk, rstn;
	logic         p0Sel, p0Enable, p0Write, p1Sel, p1Enable, p1Write;
	busPkg::addrT p0Addr, p1Addr;
	busPkg::dataT p0Wdata, p1Wdata, p0Rdata, p1Rdata;
	busPkg::strbT p0Strb, p1Strb, dqm;
	logic         p0Ready, p1Ready;
	logic         csN, rasN, casN, weN;
	logic [1:0]   ba;
	logic [11:0]  addr;
	wire  [15:0]  dq;

	int           seed;
	int           errors, checks, testBase, earlyDone, refBase, i;
	int           issuedCnt [2];
	int           servedCnt [2];
	busPkg::dataT shadow [busPkg::addrT];
	busPkg::addrT a;
	busPkg::dataT rdQ [$];
	busPkg::dataT expQ [$];
	int           portQ [$];

	tbClock clk0 (.sys_clk(sys_clk), .rstn(rstn));

	sdramSubsystem dut0 (
		.sys_clk(sys_clk), .rstn(rstn),
		.p0Sel(p0Sel), .p0Enable(p0Enable), .p0Write(p0Write), .p0Addr(p0Addr),
		.p0Wdata(p0Wdata), .p0Strb(p0Strb), .p0Rdata(p0Rdata), .p0Ready(p0Ready),
		.p1Sel(p1Sel), .p1Enable(p1Enable), .p1Write(p1Write), .p1Addr(p1Addr),
		.p1Wdata(p1Wdata), .p1Strb(p1Strb), .p1Rdata(p1Rdata), .p1Ready(p1Ready),
		.csN(csN), .rasN(rasN), .casN(casN), .weN(weN),
		.ba(ba), .addr(addr), .dq(dq), .dqm(dqm)
	);

	sdramModel model0 (
		.sys_clk(sys_clk), .rstn(rstn), .csN(csN), .rasN(rasN), .casN(casN),
		.weN(weN), .ba(ba), .addr(addr), .dq(dq), .dqm(dqm)
	);

	// Expected word after a strobed write
	function automatic busPkg::dataT mergeBytes(input busPkg::dataT old,
			input busPkg::dataT wd, input busPkg::strbT st);
		busPkg::dataT res;
		res = old;
		if (st[0])
			res[7:0] = wd[7:0];
		if (st[1])
			res[15:8] = wd[15:8];
		return res;
	endfunction

	task automatic checkData(input string name, input busPkg::dataT got, input busPkg::dataT exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic driveBus(input int port, input logic sel, input logic en, input logic wr,
			input busPkg::addrT ad, input busPkg::dataT wd, input busPkg::strbT st);
		if (port == 0) begin
			p0Sel    = sel;
			p0Enable = en;
			p0Write  = wr;
			p0Addr   = ad;
			p0Wdata  = wd;
			p0Strb   = st;
		end else begin
			p1Sel    = sel;
			p1Enable = en;
			p1Write  = wr;
			p1Addr   = ad;
			p1Wdata  = wd;
			p1Strb   = st;
		end
	endtask

	function automatic logic readyOf(input int port);
		return (port == 0) ? p0Ready : p1Ready;
	endfunction

	task automatic apbXfer(input int port, input logic wr, input busPkg::addrT ad,
			input busPkg::dataT wd, input busPkg::strbT st, output busPkg::dataT rd);
		int n;
		n = 0;
		@(posedge sys_clk);
		#2;
		driveBus(port, 1'b1, 1'b0, wr, ad, wd, st); // Setup phase
		issuedCnt[port]++;
		@(posedge sys_clk);
		#2;
		driveBus(port, 1'b1, 1'b1, wr, ad, wd, st);
		while (!readyOf(port) && n < WAIT_LIMIT) begin
			@(posedge sys_clk);
			#2;
			n++;
		end
		if (!readyOf(port)) begin
			$display("Port %0d timeout waiting for pReady", port);
			$display("TB FAILED");
			$finish;
		end else begin
			rd = (port == 0) ? p0Rdata : p1Rdata;
			@(posedge sys_clk); // Completing edge
			#2;
			driveBus(port, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		end
	endtask

	task automatic hostWrite(input int port, input busPkg::addrT ad, input busPkg::dataT wd,
			input busPkg::strbT st);
		busPkg::dataT rd;
		apbXfer(port, 1'b1, ad, wd, st, rd);
		shadow[ad] = mergeBytes(shadow.exists(ad) ? shadow[ad] : 16'hxxxx, wd, st);
	endtask

	task automatic hostRead(input int port, input busPkg::addrT ad);
		busPkg::dataT rd;
		apbXfer(port, 1'b0, ad, '0, '0, rd);
		portQ.push_back(port);
		rdQ.push_back(rd);
		expQ.push_back(shadow[ad]);
	endtask

	// Col bit 0 keeps the two hosts on disjoint words
	function automatic busPkg::addrT randAddr(input int port);
		busPkg::addrT r;
		r = busPkg::addrT'($random(seed));
		r[0] = port[0];
		return r;
	endfunction

	task automatic portTraffic(input int port, input int n);
		busPkg::addrT used [$];
		busPkg::addrT ad;
		int k;
		for (k = 0; k < n; k++) begin
			if (used.size() == 0 || ($random(seed) & 3) == 0) begin
				ad = randAddr(port);
				used.push_back(ad);
				hostWrite(port, ad, busPkg::dataT'($random(seed)), 2'b11);
			end else begin
				ad = used[$unsigned($random(seed)) % used.size()];
				if ($random(seed) & 1)
					hostWrite(port, ad, busPkg::dataT'($random(seed)),
						busPkg::strbT'($random(seed)));
				else
					hostRead(port, ad);
			end
		end
	endtask

	task automatic finishTest(input int num, input string name);
		int n;
		n = 0;
		while (rdQ.size() != 0 && n < 100) begin
			@(posedge sys_clk);
			n++;
		end
		if (rdQ.size() != 0) begin
			$display("Read comparisons still pending at end of test %0d", num);
			errors++;
		end
		$display("Test %0d %s: %0d errors", num, name, errors - testBase);
		testBase = errors;
	endtask

	// Compare every completed read with the shadow value
	always @(posedge sys_clk) begin
		while (rdQ.size() != 0)
			checkData(portQ.pop_front() ? "p1Rdata" : "p0Rdata",
				rdQ.pop_front(), expQ.pop_front());
	end

	always @(posedge sys_clk) begin
		if (p0Ready)
			servedCnt[0]++;
		if (p1Ready)
			servedCnt[1]++;
		if ((p0Ready || p1Ready) && !model0.mrsSeen)
			earlyDone++; // Completion before init finished
	end

	initial begin
		seed = 58688;
		errors = 0;
		checks = 0;
		testBase = 0;
		earlyDone = 0;
		issuedCnt[0] = 0;
		issuedCnt[1] = 0;
		servedCnt[0] = 0;
		servedCnt[1] = 0;
		driveBus(0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		driveBus(1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		i = 0;
		while (rstn !== 1'b1 && i < 100) begin
			@(posedge sys_clk);
			i++;
		end
		if (rstn !== 1'b1) begin
			$display("Reset never released");
			errors++;
		end

		// First transfer waits out the power-up sequence
		a = {2'd1, 12'h5a3, 8'h42};
		hostWrite(0, a, 16'hbeef, 2'b11);
		hostRead(0, a);
		for (i = 0; i < 16; i++) begin
			a = randAddr(0);
			a[21:20] = i[1:0]; // Every bank
			hostWrite(0, a, busPkg::dataT'($random(seed)), 2'b11);
			hostRead(0, a);
		end
		finishTest(1, "write/read over banks");

		a = {2'd2, 12'h0c7, 8'h9e};
		hostWrite(0, a, 16'h1234, 2'b11);
		hostWrite(0, a, 16'hffab, 2'b01);
		hostRead(0, a);
		hostWrite(0, a, 16'hcdff, 2'b10);
		hostRead(0, a);
		hostWrite(0, a, 16'h5555, 2'b00);
		hostRead(0, a);
		finishTest(2, "byte strobes");

		fork
			portTraffic(0, 60);
			portTraffic(1, 60);
		join
		checkCount("p0 transfers", servedCnt[0], issuedCnt[0]);
		checkCount("p1 transfers", servedCnt[1], issuedCnt[1]);
		finishTest(3, "concurrent hosts");

		checkCount("init refreshes", model0.initRefs, `SDRAM_INIT_REFRESHES);
		checkCount("mrsWord", model0.mrsWord, `SDRAM_MODE_WORD);
		checkCount("MRS before ACT", model0.mrsBeforeAct, 1);
		checkCount("early APB completions", earlyDone, 0);
		finishTest(4, "init sequence");

		refBase = model0.refreshes;
		fork
			portTraffic(0, 200);
			portTraffic(1, 200);
		join
		checks++;
		if (model0.refreshes == refBase) begin
			$display("No refresh issued during the traffic stream");
			errors++;
		end
		checks++;
		if (model0.maxRefGap > REF_BOUND) begin
			$display("Refresh gap of %0d cycles exceeds %0d", model0.maxRefGap, REF_BOUND);
			errors++;
		end
		finishTest(5, "refresh under load");

		$display("5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
busPkg.sv
sdramPkg.sv
apbPort.sv
portArbiter.sv
sdramController.sv
sdramSubsystem.sv
tbClock.sv
sdramModel.sv
tb_sdram.sv

// ==== Makefile ====
TOP = tb_sdram

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
